//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int TAG_W      = 19;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 4;
    localparam int LINE_WORDS = 16;
    localparam int NUM_LINES  = 128;

    // Cached view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        logic [1:0]          byte_off;  // Always 0 for instruction fetch
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  flat;     // Uncached word address
        addr_fields_t fields;
    } fetch_addr_u;

    // Tag sits in the low bits of a line
    typedef struct packed {
        logic [LINE_WORDS-1:0][31:0] data;
        logic [TAG_W-1:0]            tag;
    } line_t;

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef struct packed {
        icache_pkg::fetch_addr_u addr;
        logic                    uncached;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] inst_1;
        logic [31:0] inst_2;
        logic        second_valid;  // Low when inst_2 falls outside the line
    } fetch_resp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncached;      // 1 for single word, 0 for line burst
    } mem_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_beat_t;

endpackage

`default_nettype wire

//--- fetch_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_req_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire bus_pkg::fetch_req_t req,
    input  wire                      req_valid,
    output logic                     req_ready,
    output bus_pkg::fetch_req_t      cur_req,
    output logic                     cur_valid,
    input  wire                      cur_ready
);

    logic full;
    logic take;

    // Free slot, or the held request leaves this cycle
    assign req_ready = !full || cur_ready;
    assign take      = req_valid && req_ready;
    assign cur_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (cur_ready) begin
            full <= 1'b0;
        end
    end

    // Address stays put for the whole miss
    always_ff @(posedge clk) begin
        if (take) begin
            cur_req <= req;
        end
    end

endmodule

`default_nettype wire

//--- icache_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram (
    input  wire                               clk,
    input  wire                               wr_en,
    input  wire [icache_pkg::INDEX_W-1:0]     wr_index,
    input  wire icache_pkg::line_t            wr_line,
    input  wire [icache_pkg::INDEX_W-1:0]     rd_index,
    output icache_pkg::line_t                 rd_line
);

    // Distributed memory holding tag and data together
    icache_pkg::line_t lines [icache_pkg::NUM_LINES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines[wr_index] <= wr_line;
        end
    end

    assign rd_line = lines[rd_index];  // Async read

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                               clk,
    input  wire                               rst,
    input  wire bus_pkg::fetch_req_t          cur_req,
    input  wire                               cur_valid,
    output logic                              cur_ready,
    output bus_pkg::fetch_resp_t              res,
    output logic                              res_valid,
    input  wire                               res_ready,
    output bus_pkg::mem_req_t                 mem_req,
    output logic                              mem_req_valid,
    input  wire                               mem_req_ready,
    input  wire bus_pkg::mem_beat_t           mem_beat,
    input  wire                               mem_rvalid,
    output logic [icache_pkg::INDEX_W-1:0]    rd_index,
    input  wire icache_pkg::line_t            rd_line,
    output logic                              wr_en,
    output logic [icache_pkg::INDEX_W-1:0]    wr_index,
    output icache_pkg::line_t                 wr_line
);

    typedef enum logic [2:0] {
        IDLE,
        C_REQ,
        C_COLLECT,
        REFILL,
        U_REQ,
        U_RETURN
    } state_t;

    state_t state;
    state_t state_next;

    logic [icache_pkg::NUM_LINES-1:0]        line_valid;
    logic [icache_pkg::LINE_WORDS-1:0][31:0] line_buf;
    logic [icache_pkg::OFFSET_W-1:0]         beat_cnt;
    logic                                    unc_done;
    logic                                    take_beat;
    logic                                    hit;
    logic [icache_pkg::TAG_W-1:0]            req_tag;
    logic [icache_pkg::INDEX_W-1:0]          req_index;
    logic [icache_pkg::OFFSET_W-1:0]         req_offset;

    // Word at offset plus its neighbour inside the line
    function automatic bus_pkg::fetch_resp_t form_pair(
        input logic [icache_pkg::LINE_WORDS-1:0][31:0] words,
        input logic [icache_pkg::OFFSET_W-1:0]         offset
    );
        bus_pkg::fetch_resp_t r;
        r.inst_1       = words[offset];
        r.second_valid = ~&offset;
        r.inst_2       = &offset ? 32'd0 : words[offset + 1'b1];
        return r;
    endfunction

    assign req_tag    = cur_req.addr.fields.tag;
    assign req_index  = cur_req.addr.fields.index;
    assign req_offset = cur_req.addr.fields.offset;

    assign rd_index = req_index;
    assign wr_index = req_index;
    assign wr_line  = '{data: line_buf, tag: req_tag};

    assign hit       = line_valid[req_index] && (rd_line.tag == req_tag);
    assign unc_done  = (state == U_RETURN) && (beat_cnt != '0);
    assign take_beat = mem_rvalid && ((state == C_COLLECT) || (state == U_RETURN && !unc_done));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else if (state == REFILL) begin
            line_valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == IDLE) begin
            beat_cnt <= '0;
        end else if (take_beat) begin
            beat_cnt <= beat_cnt + 1'b1;   // Wraps to 0 after 16 beats
        end
    end

    // Beats land in address order from the line base
    always_ff @(posedge clk) begin
        if (take_beat) begin
            line_buf[beat_cnt] <= mem_beat.data;
        end
    end

    always_comb begin
        state_next       = state;
        cur_ready        = 1'b0;
        res              = '0;
        res_valid        = 1'b0;
        mem_req.addr     = cur_req.addr.flat;
        mem_req.uncached = 1'b1;
        mem_req_valid    = 1'b0;
        wr_en            = 1'b0;

        unique case (state)
            IDLE: begin
                if (cur_valid) begin
                    if (cur_req.uncached) begin
                        state_next = U_REQ;
                    end else if (hit) begin
                        res       = form_pair(rd_line.data, req_offset);
                        res_valid = 1'b1;
                        cur_ready = res_ready;
                    end else begin
                        state_next = C_REQ;
                    end
                end
            end
            C_REQ: begin
                mem_req.addr     = {req_tag, req_index, {(icache_pkg::OFFSET_W + 2){1'b0}}};
                mem_req.uncached = 1'b0;
                mem_req_valid    = 1'b1;
                if (mem_req_ready) begin
                    state_next = C_COLLECT;
                end
            end
            C_COLLECT: begin
                if (mem_rvalid && mem_beat.last) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                wr_en     = 1'b1;   // Same line written again on each stalled cycle
                res       = form_pair(line_buf, req_offset);
                res_valid = 1'b1;
                cur_ready = res_ready;
                if (res_ready) begin
                    state_next = IDLE;
                end
            end
            U_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    state_next = U_RETURN;
                end
            end
            U_RETURN: begin
                if (unc_done) begin
                    res.inst_1 = line_buf[0];
                    res_valid  = 1'b1;
                    cur_ready  = res_ready;
                    if (res_ready) begin
                        state_next = IDLE;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fetch_resp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_resp_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire bus_pkg::fetch_resp_t res,
    input  wire                       res_valid,
    output logic                      res_ready,
    output bus_pkg::fetch_resp_t      resp,
    output logic                      resp_valid,
    input  wire                       resp_ready
);

    logic full;
    logic take;

    // Empty, or being drained by the core
    assign res_ready  = !full || resp_ready;
    assign take       = res_valid && res_ready;
    assign resp_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (resp_ready) begin
            full <= 1'b0;
        end
    end

    // Holds the pair under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            resp <= res;
        end
    end

endmodule

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire bus_pkg::fetch_req_t  req,
    input  wire                       req_valid,
    output wire                       req_ready,
    output wire bus_pkg::fetch_resp_t resp,
    output wire                       resp_valid,
    input  wire                       resp_ready,
    output wire bus_pkg::mem_req_t    mem_req,
    output wire                       mem_req_valid,
    input  wire                       mem_req_ready,
    input  wire bus_pkg::mem_beat_t   mem_beat,
    input  wire                       mem_rvalid
);

    wire bus_pkg::fetch_req_t           cur_req;
    wire                                cur_valid;
    wire                                cur_ready;
    wire bus_pkg::fetch_resp_t          res;
    wire                                res_valid;
    wire                                res_ready;
    wire [icache_pkg::INDEX_W-1:0]      rd_index;
    wire icache_pkg::line_t             rd_line;
    wire                                wr_en;
    wire [icache_pkg::INDEX_W-1:0]      wr_index;
    wire icache_pkg::line_t             wr_line;

    fetch_req_stage i_req_stage (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .cur_req   (cur_req),
        .cur_valid (cur_valid),
        .cur_ready (cur_ready)
    );

    icache_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cur_req       (cur_req),
        .cur_valid     (cur_valid),
        .cur_ready     (cur_ready),
        .res           (res),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_beat      (mem_beat),
        .mem_rvalid    (mem_rvalid),
        .rd_index      (rd_index),
        .rd_line       (rd_line),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_line       (wr_line)
    );

    icache_data_ram i_data_ram (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_line  (wr_line),
        .rd_index (rd_index),
        .rd_line  (rd_line)
    );

    fetch_resp_stage i_resp_stage (
        .clk        (clk),
        .rst        (rst),
        .res        (res),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                     clk,
    input  wire                     rst,
    input  wire bus_pkg::mem_req_t  mem_req,
    input  wire                     mem_req_valid,
    output logic                    mem_req_ready,
    output bus_pkg::mem_beat_t      mem_beat,
    output logic                    mem_rvalid
);

    integer            seed;
    int                delay;
    int                num_beats;
    int                i;
    bus_pkg::mem_req_t cap;

    // Memory content rule
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ 32'hC0DE0000;
    endfunction

    initial begin
        seed          = 32'h9760;
        mem_req_ready = 1'b0;
        mem_rvalid    = 1'b0;
        mem_beat      = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_valid) begin
                cap   = mem_req;  // Held stable until accepted
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_req_ready <= 1'b1;
                @(posedge clk);
                mem_req_ready <= 1'b0;
                num_beats = cap.uncached ? 1 : 16;
                for (i = 0; i < num_beats; i++) begin
                    mem_beat.data <= word_at(cap.addr + 32'(i * 4));
                    mem_beat.last <= (i == num_beats - 1);
                    mem_rvalid    <= 1'b1;
                    @(posedge clk);
                end
                mem_rvalid <= 1'b0;
                mem_beat   <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    logic                       clk;
    logic                       rst;
    bus_pkg::fetch_req_t        req;
    logic                       req_valid;
    wire                        req_ready;
    wire bus_pkg::fetch_resp_t  resp;
    wire                        resp_valid;
    logic                       resp_ready;
    wire bus_pkg::mem_req_t     mem_req;
    wire                        mem_req_valid;
    wire                        mem_req_ready;
    wire bus_pkg::mem_beat_t    mem_beat;
    wire                        mem_rvalid;

    // Golden columns
    logic [31:0] addr_q[$];
    logic        unc_q[$];
    logic [31:0] inst1_q[$];
    logic        sv_q[$];
    logic [31:0] inst2_q[$];
    int          stall_q[$];
    logic        mem_q[$];

    int          n_tests  = 0;
    logic        loaded   = 1'b0;
    int          err_cnt  = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          mem_cnt  = 0;
    logic [31:0] mem_addr_seen;
    logic        mem_unc_seen;

    icache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .resp          (resp),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_beat      (mem_beat),
        .mem_rvalid    (mem_rvalid)
    );

    tb_mem_model i_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_beat      (mem_beat),
        .mem_rvalid    (mem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory request transfers on the top-level ports
    always @(negedge clk) begin
        if (!rst && mem_req_valid && mem_req_ready) begin
            mem_cnt       = mem_cnt + 1;
            mem_addr_seen = mem_req.addr;
            mem_unc_seen  = mem_req.uncached;
        end
    end

    task automatic load_golden();
        int          fd;
        int          n;
        int          st;
        string       line;
        logic [31:0] a;
        logic [31:0] i1;
        logic [31:0] i2;
        logic        u;
        logic        sv;
        logic        m;
        fd = $fopen("icache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file icache_golden.txt");
            err_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %b %h %b %h %d %b", a, u, i1, sv, i2, st, m);
                if (n == 7) begin
                    addr_q.push_back(a);
                    unc_q.push_back(u);
                    inst1_q.push_back(i1);
                    sv_q.push_back(sv);
                    inst2_q.push_back(i2);
                    stall_q.push_back(st);
                    mem_q.push_back(m);
                end else if (n > 0) begin
                    $display("Golden file line could not be read: %s", line);
                    err_cnt++;
                end
            end
            $fclose(fd);
        end
        n_tests = addr_q.size();
    endtask

    task automatic report_mismatch(input int k, input string what,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("mismatch at %0t: test %0d %s got %h expected %h", $time, k, what, got, exp);
    endtask

    task automatic drive_requests();
        int k;
        for (k = 0; k < n_tests; k++) begin
            req       <= {addr_q[k], unc_q[k]};
            req_valid <= 1'b1;
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);  // Request taken here
        end
        req_valid <= 1'b0;
    endtask

    task automatic check_results();
        bus_pkg::fetch_resp_t held;
        int                   k;
        int                   s;
        int                   test_err;
        int                   mem_before;
        int                   mem_seen;
        logic [31:0]          exp_addr;
        mem_before = 0;
        for (k = 0; k < n_tests; k++) begin
            test_err = 0;
            resp_ready <= (stall_q[k] == 0);
            @(negedge clk);
            while (!resp_valid) begin
                @(negedge clk);
            end
            held = resp;
            if (resp.inst_1 !== inst1_q[k]) begin
                report_mismatch(k, "inst_1", resp.inst_1, inst1_q[k]);
                test_err++;
            end
            if (resp.second_valid !== sv_q[k]) begin
                report_mismatch(k, "second_valid", resp.second_valid, sv_q[k]);
                test_err++;
            end
            if (resp.inst_2 !== inst2_q[k]) begin
                report_mismatch(k, "inst_2", resp.inst_2, inst2_q[k]);
                test_err++;
            end
            mem_seen   = mem_cnt - mem_before;
            mem_before = mem_cnt;
            if (mem_seen != int'(mem_q[k])) begin
                report_mismatch(k, "memory request count", mem_seen, mem_q[k]);
                test_err++;
            end
            // Line base for a refill, the word itself for uncached
            exp_addr = unc_q[k] ? addr_q[k] : (addr_q[k] & ~32'h3F);
            if (mem_q[k] && mem_addr_seen !== exp_addr) begin
                report_mismatch(k, "memory request address", mem_addr_seen, exp_addr);
                test_err++;
            end
            if (mem_q[k] && mem_unc_seen !== unc_q[k]) begin
                report_mismatch(k, "memory request uncached flag", mem_unc_seen, unc_q[k]);
                test_err++;
            end
            for (s = 0; s < stall_q[k]; s++) begin
                @(negedge clk);
                if (!resp_valid || resp !== held) begin
                    $display("Test %0d result changed or vanished while resp_ready was low", k);
                    test_err++;
                end
                if (k < n_tests - 1 && req_ready) begin
                    $display("Test %0d req_ready stayed high behind a stalled result", k);
                    test_err++;
                end
            end
            if (stall_q[k] > 0) begin
                @(posedge clk);
                resp_ready <= 1'b1;
            end
            @(posedge clk);  // Result leaves the output register
            err_cnt += test_err;
            if (test_err == 0) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("test %0d addr %h uncached %0b stall %0d: %s", k, addr_q[k], unc_q[k],
                     stall_q[k], (test_err == 0) ? "ok" : "FAILED");
        end
    endtask

    initial begin
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        load_golden();
        if (n_tests == 0) begin
            $display("No fetches were found in the golden file");
            err_cnt++;
        end
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!req_ready || resp_valid || mem_req_valid) begin
            $display("Handshake outputs were wrong after reset");
            err_cnt++;
        end
        @(posedge clk);
        if (n_tests > 0) begin
            fork
                drive_requests();
                check_results();
            join
        end
        repeat (20) begin
            @(negedge clk);
            if (resp_valid) begin
                $display("An extra result appeared after the last fetch");
                err_cnt++;
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the golden file length
    initial begin
        wait (loaded);
        repeat (16 + n_tests * 200) @(posedge clk);
        $display("Timeout: the fetches did not finish within %0d cycles", 16 + n_tests * 200);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
icache_pkg.sv
bus_pkg.sv
fetch_req_stage.sv
icache_data_ram.sv
icache_ctrl.sv
fetch_resp_stage.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - bus_pkg.sv
  - fetch_req_stage.sv
  - icache_data_ram.sv
  - icache_ctrl.sv
  - fetch_resp_stage.sv
  - icache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_icache.sv

//--- icache_golden.txt
# addr uncached inst_1 second_valid inst_2 stall mem_req
# hex  bit      hex    bit          hex    cycles bit
00001000 0 C0DE1000 1 C0DE1004 2 1
00001008 0 C0DE1008 1 C0DE100C 0 0
0000103C 0 C0DE103C 0 00000000 0 0
0000207C 0 C0DE207C 0 00000000 0 1
0000207C 0 C0DE207C 0 00000000 0 0
00001010 1 C0DE1010 0 00000000 3 1
00001010 0 C0DE1010 1 C0DE1014 0 0
00003004 0 C0DE3004 1 C0DE3008 0 1
00001000 0 C0DE1000 1 C0DE1004 0 1
00001020 0 C0DE1020 1 C0DE1024 5 0
00001024 0 C0DE1024 1 C0DE1028 3 0
00001028 0 C0DE1028 1 C0DE102C 0 0
80000040 0 40DE0040 1 40DE0044 4 1
8000007C 1 40DE007C 0 00000000 2 1
80000078 0 40DE0078 1 40DE007C 0 0
0000207C 0 C0DE207C 0 00000000 0 1
